/* hw/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data path word
`define MEM_DATA_W 32

// byte address into data ram
`define MEM_ADDR_W 32

// one select bit per byte lane
`define MEM_SEL_W 4

// register file index
`define REG_ADDR_W 5

`endif

/* hw/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

    // memory operation issued to the access stage
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,    // register-only, result is the alu value
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_LWL  = 4'd6,    // left part, merged with old reg
        MEM_LWR  = 4'd7,    // right part, merged with old reg
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SWL  = 4'd11,
        MEM_SWR  = 4'd12
    } mem_op_e;

    // one data word seen as bytes or halfwords
    // big endian: element 0 sits at the lowest address and is the msb part
    typedef union packed {
        logic [0:`MEM_SEL_W-1][7:0]    b;  // b[0] = bits 31:24
        logic [0:`MEM_SEL_W/2-1][15:0] h;  // h[0] = bits 31:16
    } mem_word_u;

endpackage

/* hw/mem_request.sv */
`include "mem_params.svh"

module mem_request (
    input  logic                   valid_i,
    input  mem_pkg::mem_op_e       op_i,
    input  logic [`MEM_ADDR_W-1:0] addr_i,
    input  logic [`MEM_DATA_W-1:0] reg2_data_i,   // store source
    output logic                   mem_ce_o,
    output logic                   mem_we_o,
    output logic [`MEM_SEL_W-1:0]  mem_sel_o,     // bit 3 is the lowest address
    output logic [`MEM_ADDR_W-1:0] mem_addr_o,
    output logic [`MEM_DATA_W-1:0] mem_wdata_o
);

    logic [1:0]            offset;      // byte within word
    logic [`MEM_SEL_W-1:0] sel;
    logic                  access;      // any ram access at all
    logic                  store;
    logic                  align_addr;  // lwl/lwr/swl/swr
    mem_pkg::mem_word_u    wdata;

    assign offset = addr_i[1:0];

    assign access = (op_i != mem_pkg::MEM_NONE);

    assign store = op_i inside {mem_pkg::MEM_SB, mem_pkg::MEM_SH, mem_pkg::MEM_SW,
                                mem_pkg::MEM_SWL, mem_pkg::MEM_SWR};

    assign align_addr = op_i inside {mem_pkg::MEM_LWL, mem_pkg::MEM_LWR,
                                     mem_pkg::MEM_SWL, mem_pkg::MEM_SWR};

    // lane select, a load uses the same lanes as its store
    always_comb begin
        sel = '0;
        case (op_i)
            mem_pkg::MEM_LB, mem_pkg::MEM_LBU, mem_pkg::MEM_SB: begin
                sel = 4'b1000 >> offset;    // offset 0 -> msb lane
            end
            mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH: begin
                if (offset == 2'b00) begin
                    sel = 4'b1100;
                end else if (offset == 2'b10) begin
                    sel = 4'b0011;
                end
                // odd offset leaves sel clear
            end
            mem_pkg::MEM_LW, mem_pkg::MEM_SW: begin
                if (offset == 2'b00) begin
                    sel = 4'b1111;
                end
            end
            mem_pkg::MEM_LWL, mem_pkg::MEM_LWR: begin
                sel = 4'b1111;              // whole aligned word read
            end
            mem_pkg::MEM_SWL: begin
                sel = 4'b1111 >> offset;    // from offset to end of word
            end
            mem_pkg::MEM_SWR: begin
                sel = 4'b1111 << (2'd3 - offset);   // start of word up to offset
            end
            default: begin
                sel = '0;
            end
        endcase
    end

    // write data, placed on the lanes that sel picks
    always_comb begin
        wdata = reg2_data_i;    // sw
        case (op_i)
            mem_pkg::MEM_SB: begin
                wdata.b = {`MEM_SEL_W{reg2_data_i[7:0]}};          // byte on every lane
            end
            mem_pkg::MEM_SH: begin
                wdata.h = {(`MEM_SEL_W/2){reg2_data_i[15:0]}};    // both halves
            end
            mem_pkg::MEM_SWL: begin
                // high reg bytes land from offset onwards
                wdata = reg2_data_i >> {offset, 3'b000};
            end
            mem_pkg::MEM_SWR: begin
                // low reg bytes land up to offset
                wdata = reg2_data_i << {~offset, 3'b000};
            end
            default: begin
                wdata = reg2_data_i;
            end
        endcase
    end

    assign mem_ce_o    = valid_i & access;
    assign mem_we_o    = valid_i & store;
    assign mem_sel_o   = valid_i ? sel : '0;    // idle bus shows no lanes
    assign mem_addr_o  = align_addr ? {addr_i[`MEM_ADDR_W-1:2], 2'b00} : addr_i;
    assign mem_wdata_o = mem_we_o ? wdata : '0;

endmodule

/* hw/load_merge.sv */
`include "mem_params.svh"

module load_merge (
    input  mem_pkg::mem_op_e       op_i,
    input  logic [1:0]             offset_i,      // low address bits
    input  logic [`MEM_DATA_W-1:0] rdata_i,       // word from data ram
    input  logic [`MEM_DATA_W-1:0] reg2_data_i,   // old destination value
    input  logic [`MEM_DATA_W-1:0] alu_res_i,
    output logic [`MEM_DATA_W-1:0] wdata_o
);

    mem_pkg::mem_word_u     rword;
    logic [7:0]             byte_val;
    logic [15:0]            half_val;
    logic                   half_ok;    // even offset
    logic                   word_ok;    // offset zero
    logic [`MEM_DATA_W-1:0] lwl_keep;   // reg bytes lwl leaves alone
    logic [`MEM_DATA_W-1:0] lwr_keep;   // reg bytes lwr leaves alone
    logic [`MEM_DATA_W-1:0] lwl_data;
    logic [`MEM_DATA_W-1:0] lwr_data;

    assign rword = rdata_i;

    // big endian lane pick, offset 0 is the msb
    assign byte_val = rword.b[offset_i];
    assign half_val = rword.h[offset_i[1]];

    assign half_ok = ~offset_i[0];
    assign word_ok = (offset_i == 2'b00);

    // lwl: word moves up by offset bytes, low offset bytes stay from reg
    assign lwl_keep = ~({`MEM_DATA_W{1'b1}} << {offset_i, 3'b000});
    assign lwl_data = (rdata_i << {offset_i, 3'b000}) | (reg2_data_i & lwl_keep);

    // lwr: word moves down by 3-offset bytes, high bytes stay from reg
    assign lwr_keep = ~({`MEM_DATA_W{1'b1}} >> {~offset_i, 3'b000});
    assign lwr_data = (rdata_i >> {~offset_i, 3'b000}) | (reg2_data_i & lwr_keep);

    always_comb begin
        wdata_o = alu_res_i;    // stores and register-only ops
        case (op_i)
            mem_pkg::MEM_LB: begin
                wdata_o = {{24{byte_val[7]}}, byte_val};
            end
            mem_pkg::MEM_LBU: begin
                wdata_o = {24'b0, byte_val};
            end
            mem_pkg::MEM_LH: begin
                // misaligned halfword gives zero
                wdata_o = half_ok ? {{16{half_val[15]}}, half_val} : '0;
            end
            mem_pkg::MEM_LHU: begin
                wdata_o = half_ok ? {16'b0, half_val} : '0;
            end
            mem_pkg::MEM_LW: begin
                wdata_o = word_ok ? rdata_i : '0;   // no trap, just zero
            end
            mem_pkg::MEM_LWL: begin
                wdata_o = lwl_data;
            end
            mem_pkg::MEM_LWR: begin
                wdata_o = lwr_data;
            end
            default: begin
                wdata_o = alu_res_i;
            end
        endcase
    end

endmodule

/* hw/mem_wb_reg.sv */
`include "mem_params.svh"

module mem_wb_reg (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  logic                   reg_we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    output logic                   wb_valid_o,
    output logic                   wb_we_o,
    output logic [`REG_ADDR_W-1:0] wb_waddr_o,
    output logic [`MEM_DATA_W-1:0] wb_wdata_o
);

    // one stage of mem/wb, loads every cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_waddr_o <= '0;
            wb_wdata_o <= '0;
        end else begin
            wb_valid_o <= valid_i;              // one cycle per instruction
            wb_we_o    <= valid_i & reg_we_i;   // bubble never writes
            wb_waddr_o <= waddr_i;
            wb_wdata_o <= wdata_i;
        end
    end

endmodule

/* hw/mem_stage.sv */
`include "mem_params.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // from execute
    input  logic                   valid_i,       // one cycle per instruction
    input  mem_pkg::mem_op_e       op_i,
    input  logic [`MEM_ADDR_W-1:0] addr_i,        // effective address
    input  logic [`MEM_DATA_W-1:0] reg2_data_i,
    input  logic [`MEM_DATA_W-1:0] alu_res_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic                   reg_we_i,

    // data ram, answers in the same cycle
    input  logic [`MEM_DATA_W-1:0] mem_rdata_i,
    output logic                   mem_ce_o,
    output logic                   mem_we_o,
    output logic [`MEM_SEL_W-1:0]  mem_sel_o,
    output logic [`MEM_ADDR_W-1:0] mem_addr_o,
    output logic [`MEM_DATA_W-1:0] mem_wdata_o,

    // to write-back
    output logic                   wb_valid_o,
    output logic                   wb_we_o,
    output logic [`REG_ADDR_W-1:0] wb_waddr_o,
    output logic [`MEM_DATA_W-1:0] wb_wdata_o
);

    logic [`MEM_DATA_W-1:0] merge_data;   // result before the stage register

    mem_request i_mem_request (
        .valid_i     (valid_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .reg2_data_i (reg2_data_i),
        .mem_ce_o    (mem_ce_o),
        .mem_we_o    (mem_we_o),
        .mem_sel_o   (mem_sel_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

    load_merge i_load_merge (
        .op_i        (op_i),
        .offset_i    (addr_i[1:0]),   // unaligned byte position
        .rdata_i     (mem_rdata_i),
        .reg2_data_i (reg2_data_i),
        .alu_res_i   (alu_res_i),
        .wdata_o     (merge_data)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .reg_we_i   (reg_we_i),
        .waddr_i    (waddr_i),
        .wdata_i    (merge_data),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o)
    );

endmodule

/* bench/tb_data_ram.sv */
`include "mem_params.svh"

module tb_data_ram (
    input  logic                   clk,
    input  logic                   ce_i,
    input  logic                   we_i,
    input  logic [`MEM_SEL_W-1:0]  sel_i,     // bit 3 is the lowest address lane
    input  logic [`MEM_ADDR_W-1:0] addr_i,
    input  logic [`MEM_DATA_W-1:0] wdata_i,
    output logic [`MEM_DATA_W-1:0] rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`MEM_DATA_W-1:0] mem [0:15];   // 16 words, big endian
    logic [3:0]             widx;

    assign widx    = addr_i[5:2];                 // upper address bits wrap
    assign rdata_o = ce_i ? mem[widx] : '0;       // same-cycle answer

    // every byte holds its own byte address, words 0 and 1 overwritten
    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] <= {8'(4 * i), 8'(4 * i + 1), 8'(4 * i + 2), 8'(4 * i + 3)};
        end
        mem[0] <= 32'ha0b0c0d0;
        mem[1] <= 32'h8180ff7f;
    end

    // write only the selected lanes
    always @(posedge clk) begin
        if (ce_i && we_i) begin
            for (int l = 0; l < `MEM_SEL_W; l++) begin
                if (sel_i[l]) begin
                    mem[widx][8 * l +: 8] <= wdata_i[8 * l +: 8];
                end
            end
        end
    end

endmodule

/* bench/mem_stage_asserts.sv */
`include "mem_params.svh"

module mem_stage_asserts (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  valid_i,
    input logic                  mem_ce_i,
    input logic                  mem_we_i,
    input logic [`MEM_SEL_W-1:0] mem_sel_i,
    input logic                  wb_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // a write is always a ram access
    we_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_we_i |-> mem_ce_i)
        else $error("mem_we_o high while mem_ce_o is low");

    // idle bus shows no lanes
    sel_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !mem_ce_i |-> (mem_sel_i == '0))
        else $error("mem_sel_o nonzero while mem_ce_o is low");

    // write-back strobe is valid_i delayed by one clock
    wb_follows_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i == $past(valid_i))
        else $error("wb_valid_o does not follow valid_i by one cycle");

endmodule

bind mem_stage mem_stage_asserts i_mem_stage_asserts (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .mem_ce_i   (mem_ce_o),
    .mem_we_i   (mem_we_o),
    .mem_sel_i  (mem_sel_o),
    .wb_valid_i (wb_valid_o)
);

/* bench/tb_mem_stage.sv */
`include "mem_params.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 10;                 // cycles per write-back wait
    localparam logic [31:0] LOAD_ALU = 32'h0bad0bad; // never a load result
    localparam logic [31:0] R2       = 32'h11223344; // old reg value for loads

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    mem_pkg::mem_op_e       op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] reg2_data;
    logic [`MEM_DATA_W-1:0] alu_res;
    logic [`REG_ADDR_W-1:0] waddr;
    logic                   reg_we;
    logic [`MEM_DATA_W-1:0] mem_rdata;
    logic                   mem_ce;
    logic                   mem_we;
    logic [`MEM_SEL_W-1:0]  mem_sel;
    logic [`MEM_ADDR_W-1:0] mem_addr;
    logic [`MEM_DATA_W-1:0] mem_wdata;
    logic                   wb_valid;
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_waddr;
    logic [`MEM_DATA_W-1:0] wb_wdata;

    // stimulus table, one row per instruction
    mem_pkg::mem_op_e       tbl_op    [MAX_ROWS];
    logic [`MEM_ADDR_W-1:0] tbl_addr  [MAX_ROWS];
    logic [`MEM_SEL_W-1:0]  tbl_sel   [MAX_ROWS];   // lanes on the ram request
    logic [`MEM_DATA_W-1:0] tbl_reg2  [MAX_ROWS];
    logic [`MEM_DATA_W-1:0] tbl_alu   [MAX_ROWS];
    logic [`REG_ADDR_W-1:0] tbl_waddr [MAX_ROWS];
    logic                   tbl_we    [MAX_ROWS];
    logic [`MEM_DATA_W-1:0] tbl_exp   [MAX_ROWS];   // write-back value
    logic [`MEM_DATA_W-1:0] tbl_wd    [MAX_ROWS];   // ram write data of a store
    logic [`MEM_DATA_W-1:0] tbl_word  [MAX_ROWS];   // ram word after a store
    logic                   tbl_store [MAX_ROWS];
    logic                   tbl_burst [MAX_ROWS];   // next row follows without a gap

    int   n_rows;
    int   errors;
    int   checks;
    int   seed = 32'hd9e7;
    logic burst_mode;
    logic timed_out;

    mem_stage i_mem_stage (
        .clk (clk), .rst_n_i (rst_n), .valid_i (valid), .op_i (op), .addr_i (addr),
        .reg2_data_i (reg2_data), .alu_res_i (alu_res), .waddr_i (waddr),
        .reg_we_i (reg_we), .mem_rdata_i (mem_rdata), .mem_ce_o (mem_ce),
        .mem_we_o (mem_we), .mem_sel_o (mem_sel), .mem_addr_o (mem_addr),
        .mem_wdata_o (mem_wdata), .wb_valid_o (wb_valid), .wb_we_o (wb_we),
        .wb_waddr_o (wb_waddr), .wb_wdata_o (wb_wdata)
    );

    tb_data_ram i_data_ram (
        .clk (clk), .ce_i (mem_ce), .we_i (mem_we), .sel_i (mem_sel),
        .addr_i (mem_addr), .wdata_i (mem_wdata), .rdata_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    task automatic add_row(input mem_pkg::mem_op_e o, input logic [31:0] a,
                           input logic [3:0] sel, input logic [31:0] r2,
                           input logic [31:0] alu, input logic we,
                           input logic [31:0] exp, input logic [31:0] wd,
                           input logic [31:0] word, input logic st);
        tbl_op[n_rows]    = o;
        tbl_addr[n_rows]  = a;
        tbl_sel[n_rows]   = sel;
        tbl_reg2[n_rows]  = r2;
        tbl_alu[n_rows]   = alu;
        tbl_waddr[n_rows] = 5'(n_rows % 30 + 1);    // r0 and r31 left out
        tbl_we[n_rows]    = we;
        tbl_exp[n_rows]   = exp;
        tbl_wd[n_rows]    = wd;
        tbl_word[n_rows]  = word;
        tbl_store[n_rows] = st;
        tbl_burst[n_rows] = burst_mode;
        n_rows++;
    endtask

    task automatic add_load(input mem_pkg::mem_op_e o, input logic [31:0] a,
                            input logic [3:0] sel, input logic [31:0] r2,
                            input logic [31:0] exp);
        add_row(o, a, sel, r2, LOAD_ALU, 1'b1, exp, 32'h0, 32'h0, 1'b0);
    endtask

    // stores write back the alu value
    task automatic add_store(input mem_pkg::mem_op_e o, input logic [31:0] a,
                             input logic [3:0] sel, input logic [31:0] r2, input logic we,
                             input logic [31:0] wd, input logic [31:0] word);
        logic [31:0] alu;
        alu = 32'h57000000 | 32'(n_rows);
        add_row(o, a, sel, r2, alu, we, alu, wd, word, 1'b1);
    endtask

    task automatic add_none();
        logic [31:0] alu;
        logic [31:0] r2;
        alu = $random(seed);
        r2  = $random(seed);
        add_row(mem_pkg::MEM_NONE, 32'h40, 4'h0, r2, alu, 1'b1, alu, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic build_table();
        add_load(mem_pkg::MEM_LB,  32'h00, 4'h8, R2, 32'hffffffa0);
        add_load(mem_pkg::MEM_LB,  32'h01, 4'h4, R2, 32'hffffffb0);
        add_load(mem_pkg::MEM_LB,  32'h02, 4'h2, R2, 32'hffffffc0);
        add_load(mem_pkg::MEM_LB,  32'h03, 4'h1, R2, 32'hffffffd0);
        add_load(mem_pkg::MEM_LB,  32'h06, 4'h2, R2, 32'hffffffff);
        add_load(mem_pkg::MEM_LB,  32'h07, 4'h1, R2, 32'h0000007f);
        add_load(mem_pkg::MEM_LBU, 32'h04, 4'h8, R2, 32'h00000081);
        add_load(mem_pkg::MEM_LBU, 32'h05, 4'h4, R2, 32'h00000080);
        add_load(mem_pkg::MEM_LBU, 32'h02, 4'h2, R2, 32'h000000c0);
        add_load(mem_pkg::MEM_LH,  32'h00, 4'hc, R2, 32'hffffa0b0);
        add_load(mem_pkg::MEM_LH,  32'h04, 4'hc, R2, 32'hffff8180);
        add_load(mem_pkg::MEM_LH,  32'h06, 4'h3, R2, 32'hffffff7f);
        add_load(mem_pkg::MEM_LH,  32'h01, 4'h0, R2, 32'h00000000);   // misaligned
        add_load(mem_pkg::MEM_LHU, 32'h02, 4'h3, R2, 32'h0000c0d0);
        add_load(mem_pkg::MEM_LHU, 32'h03, 4'h0, R2, 32'h00000000);
        add_load(mem_pkg::MEM_LW,  32'h00, 4'hf, R2, 32'ha0b0c0d0);
        add_load(mem_pkg::MEM_LW,  32'h04, 4'hf, R2, 32'h8180ff7f);
        add_load(mem_pkg::MEM_LW,  32'h02, 4'h0, R2, 32'h00000000);
        add_load(mem_pkg::MEM_LW,  32'h05, 4'h0, R2, 32'h00000000);
        // lwl keeps the low offset bytes of the old reg
        add_load(mem_pkg::MEM_LWL, 32'h00, 4'hf, R2, 32'ha0b0c0d0);
        add_load(mem_pkg::MEM_LWL, 32'h01, 4'hf, R2, 32'hb0c0d044);
        add_load(mem_pkg::MEM_LWL, 32'h02, 4'hf, R2, 32'hc0d03344);
        add_load(mem_pkg::MEM_LWL, 32'h03, 4'hf, R2, 32'hd0223344);
        add_load(mem_pkg::MEM_LWL, 32'h05, 4'hf, R2, 32'h80ff7f44);
        add_load(mem_pkg::MEM_LWR, 32'h00, 4'hf, R2, 32'h112233a0);   // high bytes from reg
        add_load(mem_pkg::MEM_LWR, 32'h01, 4'hf, R2, 32'h1122a0b0);
        add_load(mem_pkg::MEM_LWR, 32'h02, 4'hf, R2, 32'h11a0b0c0);
        add_load(mem_pkg::MEM_LWR, 32'h03, 4'hf, R2, 32'ha0b0c0d0);
        // words 2 to 5 start as 08090a0b, 0c0d0e0f, 10111213, 14151617
        add_store(mem_pkg::MEM_SB,  32'h09, 4'h4, 32'h55667788, 1'b0, 32'h88888888,
                  32'h08880a0b);
        add_store(mem_pkg::MEM_SH,  32'h0a, 4'h3, 32'h55667788, 1'b0, 32'h77887788,
                  32'h08887788);
        add_store(mem_pkg::MEM_SH,  32'h0b, 4'h0, 32'haaaabbbb, 1'b0, 32'hbbbbbbbb,
                  32'h08887788);
        add_store(mem_pkg::MEM_SB,  32'h08, 4'h8, 32'h000000ee, 1'b1, 32'heeeeeeee,
                  32'hee887788);
        add_store(mem_pkg::MEM_SW,  32'h0c, 4'hf, 32'hcafef00d, 1'b0, 32'hcafef00d,
                  32'hcafef00d);
        add_store(mem_pkg::MEM_SW,  32'h0e, 4'h0, 32'h12345678, 1'b0, 32'h12345678,
                  32'hcafef00d);
        add_store(mem_pkg::MEM_SWL, 32'h0d, 4'h7, 32'h11223344, 1'b0, 32'h00112233,
                  32'hca112233);
        add_store(mem_pkg::MEM_SWR, 32'h0e, 4'he, 32'h55667788, 1'b1, 32'h66778800,
                  32'h66778833);
        add_store(mem_pkg::MEM_SWL, 32'h10, 4'hf, 32'hdeadbeef, 1'b0, 32'hdeadbeef,
                  32'hdeadbeef);
        add_store(mem_pkg::MEM_SWR, 32'h10, 4'h8, 32'haabbccdd, 1'b0, 32'hdd000000,
                  32'hddadbeef);
        add_store(mem_pkg::MEM_SWL, 32'h13, 4'h1, 32'h01020304, 1'b0, 32'h00000001,
                  32'hddadbe01);
        add_store(mem_pkg::MEM_SWR, 32'h17, 4'hf, 32'h01020304, 1'b0, 32'h01020304,
                  32'h01020304);
        add_store(mem_pkg::MEM_SH,  32'h14, 4'hc, 32'h0000abcd, 1'b1, 32'habcdabcd,
                  32'habcd0304);
        // back to back, no idle cycle between rows
        burst_mode = 1'b1;
        add_none();
        add_load(mem_pkg::MEM_LW,  32'h08, 4'hf, R2, 32'hee887788);
        add_store(mem_pkg::MEM_SB,  32'h11, 4'h4, 32'h00000042, 1'b1, 32'h42424242,
                  32'hdd42be01);
        add_none();
        add_load(mem_pkg::MEM_LBU, 32'h0f, 4'h1, R2, 32'h00000033);
        add_load(mem_pkg::MEM_LH,  32'h0e, 4'h3, R2, 32'hffff8833);
        add_store(mem_pkg::MEM_SWR, 32'h15, 4'hc, 32'ha1b2c3d4, 1'b0, 32'hc3d40000,
                  32'hc3d40304);
        add_load(mem_pkg::MEM_LWR, 32'h16, 4'hf, R2, 32'h11c3d403);
        burst_mode = 1'b0;
        add_none();
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // ram request of the instruction now on the inputs
    task automatic check_request(input mem_pkg::mem_op_e o, input logic [31:0] a,
                                 input logic [3:0] sel, input logic st,
                                 input logic [31:0] wd);
        logic [31:0] exp_addr;
        exp_addr = a;
        if (o inside {mem_pkg::MEM_LWL, mem_pkg::MEM_LWR, mem_pkg::MEM_SWL,
                      mem_pkg::MEM_SWR}) begin
            exp_addr = {a[31:2], 2'b00};    // partial word ops address the whole word
        end
        check_val("mem_ce_o", 32'(o != mem_pkg::MEM_NONE), 32'(mem_ce));
        check_val("mem_we_o", 32'(st), 32'(mem_we));
        check_val("mem_sel_o", 32'(sel), 32'(mem_sel));
        check_val("mem_addr_o", exp_addr, mem_addr);
        if (st) begin
            check_val("mem_wdata_o", wd, mem_wdata);   // write data only matters for stores
        end
    endtask

    task automatic drive_instr(input mem_pkg::mem_op_e o, input logic [31:0] a,
                               input logic [31:0] r2, input logic [31:0] alu,
                               input logic [4:0] wa, input logic we);
        valid     = 1'b1;
        op        = o;
        addr      = a;
        reg2_data = r2;
        alu_res   = alu;
        waddr     = wa;
        reg_we    = we;
    endtask

    task automatic drive_idle();
        valid = 1'b0;
        op    = mem_pkg::MEM_NONE;
    endtask

    // counts clocks until wb_valid_o, sampled 1 ns after the edge
    task automatic wait_wb(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!wb_valid && cycles < WAIT_LIMIT);
        if (!wb_valid) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout at %0t: wb_valid_o never rose within %0d cycles",
                     $time, WAIT_LIMIT);
        end
    endtask

    // issue one instruction and check its write-back, ends 2 ns after an edge
    task automatic run_instr(input mem_pkg::mem_op_e o, input logic [31:0] a,
                             input logic [31:0] r2, input logic [31:0] alu,
                             input logic [4:0] wa, input logic we, input logic [31:0] exp,
                             input logic [3:0] sel, input logic st, input logic [31:0] wd);
        int cyc;
        drive_instr(o, a, r2, alu, wa, we);
        #1;
        check_request(o, a, sel, st, wd);   // request settles in the same cycle
        wait_wb(cyc);
        if (!timed_out) begin
            check_val("wb_valid_o delay", 32'd1, 32'(cyc));
            check_val("wb_we_o", 32'(we), 32'(wb_we));
            check_val("wb_waddr_o", 32'(wa), 32'(wb_waddr));
            check_val("wb_wdata_o", exp, wb_wdata);
        end
        #1;
    endtask

    initial begin
        // idle inputs look like a store, only valid keeps the stage quiet
        valid      = 1'b0;
        op         = mem_pkg::MEM_SW;
        addr       = '0;
        reg2_data  = R2;
        alu_res    = LOAD_ALU;
        waddr      = 5'd31;
        reg_we     = 1'b1;
        rst_n      = 1'b0;
        errors     = 0;
        checks     = 0;
        n_rows     = 0;
        burst_mode = 1'b0;
        timed_out  = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        #1;
        // reset values, before an edge loads the idle inputs
        check_val("wb_valid_o", 32'd0, 32'(wb_valid));
        check_val("wb_we_o", 32'd0, 32'(wb_we));
        check_val("wb_waddr_o", 32'd0, 32'(wb_waddr));
        check_val("wb_wdata_o", 32'd0, wb_wdata);
        // nothing issued yet, stage stays quiet
        repeat (3) begin
            @(posedge clk);
            #1;
            check_val("wb_valid_o", 32'd0, 32'(wb_valid));
            check_val("wb_we_o", 32'd0, 32'(wb_we));
            check_val("mem_ce_o", 32'd0, 32'(mem_ce));
            check_val("mem_we_o", 32'd0, 32'(mem_we));
        end
        #1;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            run_instr(tbl_op[i], tbl_addr[i], tbl_reg2[i], tbl_alu[i], tbl_waddr[i],
                      tbl_we[i], tbl_exp[i], tbl_sel[i], tbl_store[i], tbl_wd[i]);
            if (tbl_store[i] && !timed_out) begin
                // read the whole word back right after the store
                run_instr(mem_pkg::MEM_LW, {tbl_addr[i][31:2], 2'b00}, R2, LOAD_ALU,
                          5'd31, 1'b1, tbl_word[i], 4'hf, 1'b0, 32'h0);
            end
            if (!tbl_burst[i]) begin
                drive_idle();
                @(posedge clk);
                #2;
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/mem_pkg.sv
hw/mem_request.sv
hw/load_merge.sv
hw/mem_wb_reg.sv
hw/mem_stage.sv
bench/tb_data_ram.sv
bench/mem_stage_asserts.sv
bench/tb_mem_stage.sv

/* Makefile */
TOP := tb_mem_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
